/* compile.f */
hw/rv_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/hazard_unit.sv
hw/reg_file.sv
hw/execute_unit.sv
hw/mem_unit.sv
hw/bus_arbiter.sv
hw/core_top.sv
sim/bus_memory.sv
sim/core_tb.sv

/* hw/bus_arbiter.sv */
// two-port memory bus arbiter, data port first
`timescale 1ns/1ps

module bus_arbiter import rv_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  bus_req_t fetch_req_i,
    output bus_rsp_t fetch_rsp_o,
    input  bus_req_t data_req_i,
    output bus_rsp_t data_rsp_o,
    output bus_req_t mem_req_o,
    input  bus_rsp_t mem_rsp_i
);

    logic lock_q;
    logic owner_q;   // 1 = data port
    logic sel_data;

    // new transfers go to data when both ask
    assign sel_data = lock_q ? owner_q : data_req_i.req;

    assign mem_req_o = sel_data ? data_req_i : fetch_req_i;

    assign data_rsp_o.ready  = sel_data & mem_rsp_i.ready;
    assign data_rsp_o.rdata  = mem_rsp_i.rdata;
    assign fetch_rsp_o.ready = ~sel_data & mem_rsp_i.ready;
    assign fetch_rsp_o.rdata = mem_rsp_i.rdata;

    ////////////////////////////////////////
    // grant held from request to ready
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lock_q  <= 1'b0;
            owner_q <= 1'b0;
        end else if (lock_q) begin
            if (mem_rsp_i.ready) lock_q <= 1'b0;
        end else if (mem_req_o.req && !mem_rsp_i.ready) begin
            lock_q  <= 1'b1;
            owner_q <= sel_data;
        end
    end

endmodule

/* hw/core_top.sv */
// five-stage core top with pipeline registers, stall control and commit report
`timescale 1ns/1ps

module core_top import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic     clk,
    input  logic     rst_n_i,
    output bus_req_t mem_req_o,
    input  bus_rsp_t mem_rsp_i,
    output logic     commit_valid_o,
    output commit_t  commit_o
);

    bus_req_t        fetch_req, data_req;
    bus_rsp_t        fetch_rsp, data_rsp;
    instr_u          fetch_instr;
    logic [XLEN-1:0] fetch_pc;
    logic            fetch_valid;
    logic            id_en, load_use, mem_busy;

    logic            id_valid, ex_valid, m_valid, wb_valid;
    logic [XLEN-1:0] id_pc, ex_pc, m_pc, wb_pc;
    instr_u          id_instr, ex_instr, m_instr, wb_instr;
    ctrl_t           id_ctrl, ex_ctrl, m_ctrl, wb_ctrl;
    logic [XLEN-1:0] rf_rdata1, rf_rdata2, op_a, op_b;
    logic [XLEN-1:0] ex_op_a, ex_op_b, ex_result;
    logic [XLEN-1:0] m_addr, m_store_data, m_result;
    logic [XLEN-1:0] wb_result;

    assign id_en = ~(load_use | mem_busy);

    fetch_unit #(.RESET_PC(RESET_PC)) u_fetch_unit (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .id_en_i       (id_en),
        .fetch_req_o   (fetch_req),
        .fetch_rsp_i   (fetch_rsp),
        .instr_o       (fetch_instr),
        .pc_o          (fetch_pc),
        .fetch_valid_o (fetch_valid)
    );

    decode_unit u_decode_unit (.instr_i(id_instr), .ctrl_o(id_ctrl));

    reg_file u_reg_file (
        .clk      (clk),
        .raddr1_i (id_ctrl.rs1),
        .raddr2_i (id_ctrl.rs2),
        .rdata1_o (rf_rdata1),
        .rdata2_o (rf_rdata2),
        .we_i     (wb_valid & wb_ctrl.reg_write),
        .waddr_i  (wb_ctrl.rd),
        .wdata_i  (wb_result)
    );

    hazard_unit u_hazard_unit (
        .id_valid_i  (id_valid),
        .id_ctrl_i   (id_ctrl),
        .ex_valid_i  (ex_valid),
        .ex_ctrl_i   (ex_ctrl),
        .ex_result_i (ex_result),
        .m_valid_i   (m_valid),
        .m_ctrl_i    (m_ctrl),
        .m_result_i  (m_result),
        .wb_valid_i  (wb_valid),
        .wb_ctrl_i   (wb_ctrl),
        .wb_result_i (wb_result),
        .rf_rdata1_i (rf_rdata1),
        .rf_rdata2_i (rf_rdata2),
        .op_a_o      (op_a),
        .op_b_o      (op_b),
        .load_use_o  (load_use)
    );

    execute_unit u_execute_unit (
        .ctrl_i   (ex_ctrl),
        .op_a_i   (ex_op_a),
        .op_b_i   (ex_op_b),
        .result_o (ex_result)
    );

    mem_unit u_mem_unit (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .valid_i      (m_valid),
        .ctrl_i       (m_ctrl),
        .addr_i       (m_addr),
        .store_data_i (m_store_data),
        .data_req_o   (data_req),
        .data_rsp_i   (data_rsp),
        .result_o     (m_result),
        .busy_o       (mem_busy)
    );

    bus_arbiter u_bus_arbiter (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .fetch_req_i (fetch_req),
        .fetch_rsp_o (fetch_rsp),
        .data_req_i  (data_req),
        .data_rsp_o  (data_rsp),
        .mem_req_o   (mem_req_o),
        .mem_rsp_i   (mem_rsp_i)
    );

    ////////////////////////////////////////
    // stage valid chain
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            id_valid <= 1'b0;
            ex_valid <= 1'b0;
            m_valid  <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            if (id_en) id_valid <= fetch_valid;  // bubble if no word held
            if (!mem_busy) begin
                ex_valid <= id_valid & ~load_use;
                m_valid  <= ex_valid;
            end
            wb_valid <= m_valid & ~mem_busy;
        end
    end

    ////////////////////////////////////////
    // stage payload
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (id_en) begin
            id_pc    <= fetch_pc;
            id_instr <= fetch_instr;
        end
        if (!mem_busy) begin
            ex_pc        <= id_pc;
            ex_instr     <= id_instr;
            ex_ctrl      <= id_ctrl;
            ex_op_a      <= op_a;  // forwarded values
            ex_op_b      <= op_b;
            m_pc         <= ex_pc;
            m_instr      <= ex_instr;
            m_ctrl       <= ex_ctrl;
            m_addr       <= ex_result;
            m_store_data <= ex_op_b;
        end
        wb_pc     <= m_pc;
        wb_instr  <= m_instr;
        wb_ctrl   <= m_ctrl;
        wb_result <= m_result;
    end

    // commit report, one cycle behind wb
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            commit_valid_o <= 1'b0;
        end else begin
            commit_valid_o <= wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        commit_o.pc    <= wb_pc;
        commit_o.instr <= wb_instr;
        commit_o.we    <= wb_valid & wb_ctrl.reg_write;
        commit_o.rd    <= wb_ctrl.rd;
        commit_o.wdata <= wb_result;
    end

endmodule

/* hw/decode_unit.sv */
// instruction decoder producing register indices, immediate and control
`timescale 1ns/1ps

module decode_unit import rv_pkg::*; (
    input  instr_u instr_i,
    output ctrl_t  ctrl_o
);

    // shared by register and immediate forms
    function automatic alu_op_e funct_to_alu(input logic [2:0] funct3, input logic alt);
        alu_op_e op;
        case (funct3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b010:  op = ALU_SLT;
            3'b100:  op = ALU_XOR;
            3'b110:  op = ALU_OR;
            3'b111:  op = ALU_AND;
            default: op = ALU_ADD;
        endcase
        return op;
    endfunction

    logic [XLEN-1:0] imm_i;
    logic [XLEN-1:0] imm_s;
    logic [XLEN-1:0] imm_u;

    assign imm_i = {{52{instr_i.i.imm[11]}}, instr_i.i.imm};
    assign imm_s = {{52{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_u = {{32{instr_i.u.imm[19]}}, instr_i.u.imm, 12'b0};

    always_comb begin
        ctrl_o        = '0;  // unknown opcode ends up as a nop
        ctrl_o.alu_op = ALU_ADD;
        case (instr_i.r.opcode)
            OP: begin
                ctrl_o.rd        = instr_i.r.rd;
                ctrl_o.rs1       = instr_i.r.rs1;
                ctrl_o.rs2       = instr_i.r.rs2;
                ctrl_o.alu_op    = funct_to_alu(instr_i.r.funct3, instr_i.r.funct7[5]);
                ctrl_o.reg_write = |instr_i.r.rd;
            end
            OP_IMM: begin
                ctrl_o.rd        = instr_i.i.rd;
                ctrl_o.rs1       = instr_i.i.rs1;
                ctrl_o.imm       = imm_i;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.alu_op    = funct_to_alu(instr_i.i.funct3, 1'b0);
                ctrl_o.reg_write = |instr_i.i.rd;
            end
            LUI: begin
                ctrl_o.rd        = instr_i.u.rd;
                ctrl_o.imm       = imm_u;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.alu_op    = ALU_PASS_B;
                ctrl_o.reg_write = |instr_i.u.rd;
            end
            LOAD: begin
                ctrl_o.rd        = instr_i.i.rd;
                ctrl_o.rs1       = instr_i.i.rs1;
                ctrl_o.imm       = imm_i;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.mem_read  = 1'b1;
                ctrl_o.reg_write = |instr_i.i.rd;
            end
            STORE: begin
                ctrl_o.rs1       = instr_i.s.rs1;
                ctrl_o.rs2       = instr_i.s.rs2;  // store data
                ctrl_o.imm       = imm_s;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.mem_write = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* hw/execute_unit.sv */
// alu with register or immediate second operand
`timescale 1ns/1ps

module execute_unit import rv_pkg::*; (
    input  ctrl_t           ctrl_i,
    input  logic [XLEN-1:0] op_a_i,
    input  logic [XLEN-1:0] op_b_i,
    output logic [XLEN-1:0] result_o
);

    logic [XLEN-1:0] b;

    assign b = ctrl_i.use_imm ? ctrl_i.imm : op_b_i;

    always_comb begin
        case (ctrl_i.alu_op)
            ALU_ADD:    result_o = op_a_i + b;  // also ld/sd address
            ALU_SUB:    result_o = op_a_i - b;
            ALU_AND:    result_o = op_a_i & b;
            ALU_OR:     result_o = op_a_i | b;
            ALU_XOR:    result_o = op_a_i ^ b;
            ALU_SLT:    result_o = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(b)};
            ALU_PASS_B: result_o = b;  // lui
            default:    result_o = '0;
        endcase
    end

endmodule

/* hw/fetch_unit.sv */
// fetch unit with pc register and one-word holding register
`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; #(
    parameter logic [XLEN-1:0] RESET_PC = '0
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            id_en_i,
    output bus_req_t        fetch_req_o,
    input  bus_rsp_t        fetch_rsp_i,
    output instr_u          instr_o,
    output logic [XLEN-1:0] pc_o,
    output logic            fetch_valid_o
);

    logic [XLEN-1:0] fetch_pc_q;  // address of the next word to fetch
    logic [XLEN-1:0] pc_q;
    instr_u          instr_q;
    logic            full_q;
    logic            consume;

    assign consume = full_q & id_en_i;

    // ask again as soon as the held word is being taken
    assign fetch_req_o.req   = ~full_q | id_en_i;
    assign fetch_req_o.we    = 1'b0;
    assign fetch_req_o.addr  = fetch_pc_q;
    assign fetch_req_o.wdata = '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            full_q     <= 1'b0;
            fetch_pc_q <= RESET_PC;
        end else if (fetch_rsp_i.ready) begin
            full_q     <= 1'b1;  // refill wins over consume
            fetch_pc_q <= fetch_pc_q + XLEN'(4);
        end else if (consume) begin
            full_q <= 1'b0;
        end
    end

    // bus word is 64 bits, pick the half holding this pc
    always_ff @(posedge clk) begin
        if (fetch_rsp_i.ready) begin
            pc_q    <= fetch_pc_q;
            instr_q <= fetch_pc_q[2] ? fetch_rsp_i.rdata[63:32] : fetch_rsp_i.rdata[31:0];
        end
    end

    assign instr_o       = instr_q;
    assign pc_o          = pc_q;
    assign fetch_valid_o = full_q;

endmodule

/* hw/hazard_unit.sv */
// raw hazard detection, operand forwarding and load-use stall
`timescale 1ns/1ps

module hazard_unit import rv_pkg::*; (
    input  logic            id_valid_i,
    input  ctrl_t           id_ctrl_i,
    input  logic            ex_valid_i,
    input  ctrl_t           ex_ctrl_i,
    input  logic [XLEN-1:0] ex_result_i,
    input  logic            m_valid_i,
    input  ctrl_t           m_ctrl_i,
    input  logic [XLEN-1:0] m_result_i,
    input  logic            wb_valid_i,
    input  ctrl_t           wb_ctrl_i,
    input  logic [XLEN-1:0] wb_result_i,
    input  logic [XLEN-1:0] rf_rdata1_i,
    input  logic [XLEN-1:0] rf_rdata2_i,
    output logic [XLEN-1:0] op_a_o,
    output logic [XLEN-1:0] op_b_o,
    output logic            load_use_o
);

    // a stage writes the register this source reads
    function automatic logic hit(input logic valid, input ctrl_t c,
                                 input logic [REG_ADDR_W-1:0] rs);
        return valid && c.reg_write && (c.rd == rs) && (rs != '0);
    endfunction

    function automatic logic [XLEN-1:0] forward(input logic [REG_ADDR_W-1:0] rs,
                                                input logic [XLEN-1:0] rf_val);
        logic [XLEN-1:0] val;
        val = rf_val;
        if (hit(ex_valid_i, ex_ctrl_i, rs)) begin
            val = ex_result_i;  // youngest first
        end else if (hit(m_valid_i, m_ctrl_i, rs)) begin
            val = m_result_i;
        end else if (hit(wb_valid_i, wb_ctrl_i, rs)) begin
            val = wb_result_i;  // also covers the same-cycle write
        end
        return val;
    endfunction

    always_comb begin
        op_a_o = forward(id_ctrl_i.rs1, rf_rdata1_i);
        op_b_o = forward(id_ctrl_i.rs2, rf_rdata2_i);
    end

    // load data is not there yet while the load sits in EX
    assign load_use_o = id_valid_i && ex_ctrl_i.mem_read &&
                        (hit(ex_valid_i, ex_ctrl_i, id_ctrl_i.rs1) ||
                         hit(ex_valid_i, ex_ctrl_i, id_ctrl_i.rs2));

endmodule

/* hw/mem_unit.sv */
// load/store sequencer on the data port with result select
`timescale 1ns/1ps

module mem_unit import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            valid_i,
    input  ctrl_t           ctrl_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] store_data_i,
    output bus_req_t        data_req_o,
    input  bus_rsp_t        data_rsp_i,
    output logic [XLEN-1:0] result_o,
    output logic            busy_o
);

    logic            access;
    logic            done_q;   // transfer finished, instruction leaves this cycle
    logic [XLEN-1:0] rdata_q;

    assign access = valid_i & (ctrl_i.mem_read | ctrl_i.mem_write);

    // busy until the completion is registered, so one issue per instruction
    assign busy_o = access & ~done_q;

    assign data_req_o.req   = busy_o;
    assign data_req_o.we    = ctrl_i.mem_write;
    assign data_req_o.addr  = addr_i;
    assign data_req_o.wdata = store_data_i;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            done_q <= 1'b0;
        end else begin
            done_q <= busy_o & data_rsp_i.ready;
        end
    end

    always_ff @(posedge clk) begin
        if (data_rsp_i.ready) begin
            rdata_q <= data_rsp_i.rdata;
        end
    end

    assign result_o = ctrl_i.mem_read ? rdata_q : addr_i;

endmodule

/* hw/reg_file.sv */
// integer register file, two read ports and one write port
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic                  clk,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i
);

    logic [XLEN-1:0] regs [1:31];  // no storage for x0

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

/* hw/rv_pkg.sv */
// widths, opcodes, alu codes, instruction formats, bus and commit structs
package rv_pkg;

    localparam int XLEN       = 64;
    localparam int REG_ADDR_W = 5;

    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011
    } op_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    ////////////////////////////////////////
    // instruction word views
    ////////////////////////////////////////
    typedef struct packed {
        logic [6:0]            funct7;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]           imm;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]            imm_hi;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [2:0]            funct3;
        logic [4:0]            imm_lo;
        logic [6:0]            opcode;
    } s_fmt_t;

    typedef struct packed {
        logic [19:0]           imm;
        logic [REG_ADDR_W-1:0] rd;
        logic [6:0]            opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        u_fmt_t u;
    } instr_u;

    ////////////////////////////////////////
    // control, bus and commit bundles
    ////////////////////////////////////////
    typedef struct packed {
        logic [REG_ADDR_W-1:0] rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  mem_read;
        logic                  mem_write;
        logic                  reg_write;
    } ctrl_t;

    typedef struct packed {
        logic            req;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic            ready;
        logic [XLEN-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [31:0]           instr;
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       wdata;
    } commit_t;

endpackage

/* sim/bus_memory.sv */
// testbench memory, 4 KB of 64-bit words, ready after a random delay
`timescale 1ns/1ps

module bus_memory import rv_pkg::*; #(
    parameter logic [63:0] SEED  = 64'd1265,
    parameter int          WORDS = 512
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  bus_req_t req_i,
    output bus_rsp_t rsp_o
);

    localparam int IDX_W = $clog2(WORDS);

    logic [XLEN-1:0]  mem [WORDS];  // contents loaded by the testbench
    logic [63:0]      rng_state;
    logic [1:0]       wait_cnt;     // cycles still to wait on this transfer
    logic [IDX_W-1:0] idx;

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    assign idx = req_i.addr[IDX_W+2:3];

    initial begin
        rng_state = SEED;
        wait_cnt  = 2'(next_rand());
        rsp_o     = '0;
    end

    always @(posedge clk) begin
        if (!rst_n_i) begin
            rsp_o.ready <= 1'b0;
        end else if (rsp_o.ready) begin
            rsp_o.ready <= 1'b0;  // single pulse, next request starts after it
        end else if (req_i.req) begin
            if (wait_cnt == 2'd0) begin
                rsp_o.ready <= 1'b1;
                rsp_o.rdata <= mem[idx];
                if (req_i.we) begin
                    mem[idx] <= req_i.wdata;
                end
                wait_cnt <= 2'(next_rand());  // delay of the next transfer
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

endmodule

/* sim/core_tb.sv */
// testbench top with clock, reset, random program, isa model, commit checker and watchdog
`timescale 1ns/1ps

module core_tb import rv_pkg::*; ();

    localparam int          N_INSTR        = 200;
    localparam int          RESET_CYCLES   = 10;
    localparam int          CODE_WORDS     = 256;  // 0x000 to 0x7ff
    localparam int          MEM_WORDS      = 512;
    localparam int          TIMEOUT_CYCLES = N_INSTR * (4 + 2 * 4) + 100;
    localparam logic [63:0] RESET_PC       = '0;
    localparam logic [31:0] NOP            = 32'h0000_0013;  // addi x0, x0, 0

    typedef enum int {K_ADDI, K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT, K_LUI, K_LD, K_SD} kind_e;

    logic     clk;
    logic     rst_n_i;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;
    logic     commit_valid;
    commit_t  commit;
    bus_req_t last_req;          // bus request seen at the previous edge
    logic     req_open = 1'b0;   // that request had no ready yet

    logic [63:0] rng_state = 64'd1265;
    kind_e       prog_kind [N_INSTR];
    logic [4:0]  prog_rd   [N_INSTR];
    logic [4:0]  prog_rs1  [N_INSTR];
    logic [4:0]  prog_rs2  [N_INSTR];
    logic [19:0] prog_imm  [N_INSTR];
    logic [31:0] prog_word [N_INSTR];
    logic [63:0] model_reg [32];
    logic [63:0] model_mem [MEM_WORDS];
    int          n_commit = 0;
    int          checks   = 0;
    int          errors   = 0;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    core_top #(.RESET_PC(RESET_PC)) u_core_top (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .mem_req_o      (mem_req),
        .mem_rsp_i      (mem_rsp),
        .commit_valid_o (commit_valid),
        .commit_o       (commit)
    );

    bus_memory #(.SEED(64'd1265), .WORDS(MEM_WORDS)) u_bus_memory (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .req_i   (mem_req),
        .rsp_o   (mem_rsp)
    );

    function automatic logic [63:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    ////////////////////////////////////////
    // program generation
    ////////////////////////////////////////
    function automatic logic [31:0] encode(input kind_e k, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [19:0] imm);
        logic [31:0] w;
        case (k)
            K_ADDI:  w = {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
            K_ADD:   w = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_SUB:   w = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
            K_AND:   w = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
            K_OR:    w = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
            K_XOR:   w = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
            K_SLT:   w = {7'b0000000, rs2, rs1, 3'b010, rd, 7'b0110011};
            K_LUI:   w = {imm, rd, 7'b0110111};
            K_LD:    w = {imm[11:0], rs1, 3'b011, rd, 7'b0000011};
            default: w = {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};  // sd
        endcase
        return w;
    endfunction

    task automatic build_program();
        logic [63:0] r;
        logic [11:0] off;
        logic [11:0] last_off;
        kind_e       k;
        last_off = 12'h800;
        for (int n = 0; n < N_INSTR; n++) begin
            r           = next_rand();
            k           = kind_e'(int'(r[23:16]) % 10);
            prog_rd[n]  = {2'b00, r[2:0]};
            prog_rs1[n] = {2'b00, r[5:3]};
            prog_rs2[n] = {2'b00, r[8:6]};
            prog_imm[n] = r[63:44];
            if (n < 7) begin
                k           = K_ADDI;  // x1..x7 get a defined value first
                prog_rd[n]  = 5'(n + 1);
                prog_rs1[n] = 5'd0;
            end else if (prog_kind[n-1] == K_LD && r[40]) begin
                prog_rs1[n] = prog_rd[n-1];  // load-use pair
            end
            if (k == K_LD || k == K_SD) begin
                // reuse the last store address half the time
                off         = r[41] ? last_off : {1'b1, r[49:42], 3'b000};
                prog_rs1[n] = 5'd0;
                prog_imm[n] = {8'h00, off};
                if (k == K_SD) begin
                    last_off = off;
                end
            end
            prog_kind[n] = k;
            prog_word[n] = encode(k, prog_rd[n], prog_rs1[n], prog_rs2[n], prog_imm[n]);
        end
    endtask

    function automatic logic [31:0] code_at(input int n);
        return (n < N_INSTR) ? prog_word[n] : NOP;
    endfunction

    task automatic load_memory();
        logic [63:0] d;
        for (int w = 0; w < MEM_WORDS; w++) begin
            if (w < CODE_WORDS) begin
                d = {code_at(2 * w + 1), code_at(2 * w)};  // two instructions per word
            end else begin
                d = next_rand();
            end
            u_bus_memory.mem[w] = d;
            model_mem[w]        = d;
        end
        for (int i = 0; i < 32; i++) begin
            model_reg[i] = '0;
        end
    endtask

    ////////////////////////////////////////
    // isa model and commit checker
    ////////////////////////////////////////
    task automatic report_value(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        errors++;
        $display("FAIL %s expected %h actual %h", name, exp, act);
    endtask

    task automatic check_commit(input commit_t c);
        logic [63:0] a, b, imm_i, res, addr, exp_pc;
        logic        we;
        string       tag;
        a      = model_reg[prog_rs1[n_commit]];
        b      = model_reg[prog_rs2[n_commit]];
        imm_i  = {{52{prog_imm[n_commit][11]}}, prog_imm[n_commit][11:0]};
        addr   = a + imm_i;
        exp_pc = RESET_PC + 64'(4 * n_commit);
        we     = 1'b1;
        res    = '0;
        case (prog_kind[n_commit])
            K_ADDI: res = a + imm_i;
            K_ADD:  res = a + b;
            K_SUB:  res = a - b;
            K_AND:  res = a & b;
            K_OR:   res = a | b;
            K_XOR:  res = a ^ b;
            K_SLT:  res = {63'b0, $signed(a) < $signed(b)};
            K_LUI:  res = {{32{prog_imm[n_commit][19]}}, prog_imm[n_commit], 12'b0};
            K_LD:   res = model_mem[addr[11:3]];
            K_SD: begin
                model_mem[addr[11:3]] = b;
                we = 1'b0;
            end
            default: we = 1'b0;
        endcase
        we  = we && (prog_rd[n_commit] != 5'd0);  // x0 never written
        tag = $sformatf("commit %0d", n_commit);
        checks++;
        assert (c.pc == exp_pc) else report_value({tag, " pc"}, exp_pc, c.pc);
        assert (c.instr == prog_word[n_commit])
            else report_value({tag, " instr"}, 64'(prog_word[n_commit]), 64'(c.instr));
        assert (c.we == we) else report_value({tag, " we"}, 64'(we), 64'(c.we));
        if (we) begin
            assert (c.rd == prog_rd[n_commit])
                else report_value({tag, " rd"}, 64'(prog_rd[n_commit]), 64'(c.rd));
            assert (c.wdata == res) else report_value({tag, " wdata"}, res, c.wdata);
            model_reg[prog_rd[n_commit]] = res;
        end
    endtask

    always @(posedge clk) begin
        if (rst_n_i && commit_valid && n_commit < N_INSTR) begin
            check_commit(commit);
            n_commit++;
        end
    end

    // an open bus request keeps req, we, addr and wdata until ready
    always @(posedge clk) begin
        if (!rst_n_i) begin
            req_open <= 1'b0;
        end else begin
            if (req_open) begin
                assert (mem_req == last_req) else begin
                    errors++;
                    $display("memory request changed or was dropped before ready");
                end
            end
            req_open <= mem_req.req && !mem_rsp.ready;
            last_req <= mem_req;
        end
    end

    ////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////
    initial begin
        rst_n_i = 1'b0;
        build_program();
        load_memory();
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(posedge clk);
            if (i > 0) begin  // first edge applies the reset
                assert (commit_valid === 1'b0) else begin
                    errors++;
                    $display("commit_valid_o was not low during reset");
                end
            end
        end
        rst_n_i <= 1'b1;
        wait (n_commit == N_INSTR);
        repeat (5) @(posedge clk);
        $display("commits %0d, checks %0d, errors %0d", n_commit, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        repeat (RESET_CYCLES + TIMEOUT_CYCLES) @(posedge clk);
        $display("run timed out with %0d of %0d instructions committed", n_commit, N_INSTR);
        $display("commits %0d, checks %0d, errors %0d", n_commit, checks, errors);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
